/* Makefile */
VERILATOR  ?= verilator
VFLAGS     ?= --binary --assert --timing -j 0
LINT_FLAGS ?= --lint-only -Wall --timing
TOP        := tb_lc3b_cpu
FILELIST   := tb.f
OBJ_DIR    := obj_dir
PASS_MSG   := ALL CHECKS PASSED

.PHONY: all run lint clean

all: run

run:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* src/lc3b_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_alu (
	input  lc3b_pkg::lc3b_aluop aluop,
	input  lc3b_pkg::lc3b_word  a,
	input  lc3b_pkg::lc3b_word  b,
	output lc3b_pkg::lc3b_word  f
);

	always_comb begin
		case (aluop)
			lc3b_pkg::alu_add: f = a + b;
			lc3b_pkg::alu_and: f = a & b;
			lc3b_pkg::alu_not: f = ~a;
			lc3b_pkg::alu_pass: f = a;
			// Shift amount is the low nibble of b
			lc3b_pkg::alu_sll: f = a << b[3:0];
			lc3b_pkg::alu_srl: f = a >> b[3:0];
			lc3b_pkg::alu_sra: f = lc3b_pkg::lc3b_word'($signed(a) >>> b[3:0]);
			default: f = a;
		endcase
	end

endmodule

`default_nettype wire

/* src/lc3b_control.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_control (
	input  logic                  clk,
	input  logic                  rst,
	input  lc3b_pkg::lc3b_ir_info ir_info,
	input  logic                  mem_resp,
	output lc3b_pkg::lc3b_ctrl    ctrl,
	output logic                  mem_read,
	output logic                  mem_write
);

	typedef enum logic [4:0] {
		fetch1,
		fetch2,
		fetch3,
		decode,
		s_add,
		s_and,
		s_not,
		s_br,
		br_taken,
		calc_addr,
		lea,
		jmp,
		ldr1,
		ldr2,
		str1,
		str2,
		shf
	} state_t;

	state_t state, next_state;

	always_comb begin : state_actions
		ctrl = '0;
		ctrl.aluop = lc3b_pkg::alu_add;
		mem_read = 1'b0;
		mem_write = 1'b0;

		case (state)
			fetch1: begin
				// MAR <= PC, PC <= PC + 2
				ctrl.marmux_sel = 1'b1;
				ctrl.load_mar = 1'b1;
				ctrl.pcmux_sel = 2'b00;
				ctrl.load_pc = 1'b1;
			end
			fetch2: begin
				mem_read = 1'b1;
				ctrl.mdrmux_sel = 1'b1;
				ctrl.load_mdr = 1'b1;
			end
			fetch3: begin
				ctrl.load_ir = 1'b1;
			end
			s_add, s_and: begin
				ctrl.aluop = (state == s_and) ? lc3b_pkg::alu_and : lc3b_pkg::alu_add;
				// Immediate or second register operand
				ctrl.alumux_sel = ir_info.imm_flag ? 2'b01 : 2'b00;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			s_not: begin
				ctrl.aluop = lc3b_pkg::alu_not;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			br_taken: begin
				ctrl.pcmux_sel = 2'b01;
				ctrl.load_pc = 1'b1;
			end
			calc_addr: begin
				// MAR <= BaseR + offset6
				ctrl.alumux_sel = 2'b10;
				ctrl.load_mar = 1'b1;
			end
			lea: begin
				ctrl.regfilemux_sel = 2'b10;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			jmp: begin
				ctrl.aluop = lc3b_pkg::alu_pass;
				ctrl.pcmux_sel = 2'b10;
				ctrl.load_pc = 1'b1;
			end
			ldr1: begin
				mem_read = 1'b1;
				ctrl.mdrmux_sel = 1'b1;
				ctrl.load_mdr = 1'b1;
			end
			ldr2: begin
				ctrl.regfilemux_sel = 2'b01;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			str1: begin
				// MDR <= SR through the ALU
				ctrl.storemux_sel = 1'b1;
				ctrl.aluop = lc3b_pkg::alu_pass;
				ctrl.load_mdr = 1'b1;
			end
			str2: begin
				mem_write = 1'b1;
			end
			shf: begin
				if (!ir_info.shift_right) begin
					ctrl.aluop = lc3b_pkg::alu_sll;
				end else if (ir_info.shift_arith) begin
					ctrl.aluop = lc3b_pkg::alu_sra;
				end else begin
					ctrl.aluop = lc3b_pkg::alu_srl;
				end
				ctrl.alumux_sel = 2'b11;
				ctrl.load_regfile = 1'b1;
				ctrl.load_cc = 1'b1;
			end
			default: begin
				// decode and s_br only steer the next state
			end
		endcase
	end

	always_comb begin : next_state_logic
		next_state = fetch1;
		case (state)
			fetch1: next_state = fetch2;
			fetch2: next_state = mem_resp ? fetch3 : fetch2;
			fetch3: next_state = decode;
			decode: begin
				case (ir_info.opcode)
					lc3b_pkg::op_add: next_state = s_add;
					lc3b_pkg::op_and: next_state = s_and;
					lc3b_pkg::op_not: next_state = s_not;
					lc3b_pkg::op_br: next_state = s_br;
					lc3b_pkg::op_ldr: next_state = calc_addr;
					lc3b_pkg::op_str: next_state = calc_addr;
					lc3b_pkg::op_lea: next_state = calc_addr;
					lc3b_pkg::op_jmp: next_state = jmp;
					lc3b_pkg::op_shf: next_state = shf;
					default: next_state = fetch1;
				endcase
			end
			calc_addr: begin
				case (ir_info.opcode)
					lc3b_pkg::op_ldr: next_state = ldr1;
					lc3b_pkg::op_str: next_state = str1;
					lc3b_pkg::op_lea: next_state = lea;
					default: next_state = fetch1;
				endcase
			end
			s_br: next_state = ir_info.branch_enable ? br_taken : fetch1;
			ldr1: next_state = mem_resp ? ldr2 : ldr1;
			str1: next_state = str2;
			str2: next_state = mem_resp ? fetch1 : str2;
			default: next_state = fetch1;
		endcase
	end

	always_ff @(posedge clk) begin : state_reg
		if (rst) begin
			state <= fetch1;
		end else begin
			state <= next_state;
		end
	end

endmodule

`default_nettype wire

/* src/lc3b_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu #(
	parameter lc3b_pkg::lc3b_word RESET_PC = 16'h0000
) (
	input  logic                    clk,
	input  logic                    rst,
	output lc3b_pkg::lc3b_word      mem_address,
	output lc3b_pkg::lc3b_word      mem_wdata,
	output logic                    mem_read,
	output logic                    mem_write,
	output lc3b_pkg::lc3b_mem_wmask mem_byte_enable,
	input  lc3b_pkg::lc3b_word      mem_rdata,
	input  logic                    mem_resp
);

	lc3b_pkg::lc3b_ctrl    ctrl;
	lc3b_pkg::lc3b_ir_info ir_info;

	// Only full word accesses in this subset
	assign mem_byte_enable = 2'b11;

	lc3b_control u_control (
		.clk       (clk),
		.rst       (rst),
		.ir_info   (ir_info),
		.mem_resp  (mem_resp),
		.ctrl      (ctrl),
		.mem_read  (mem_read),
		.mem_write (mem_write)
	);

	lc3b_datapath #(
		.RESET_PC (RESET_PC)
	) u_datapath (
		.clk         (clk),
		.rst         (rst),
		.ctrl        (ctrl),
		.mem_rdata   (mem_rdata),
		.ir_info     (ir_info),
		.mem_address (mem_address),
		.mem_wdata   (mem_wdata)
	);

endmodule

`default_nettype wire

/* src/lc3b_datapath.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_datapath #(
	parameter lc3b_pkg::lc3b_word RESET_PC = 16'h0000
) (
	input  logic                  clk,
	input  logic                  rst,
	input  lc3b_pkg::lc3b_ctrl    ctrl,
	input  lc3b_pkg::lc3b_word    mem_rdata,
	output lc3b_pkg::lc3b_ir_info ir_info,
	output lc3b_pkg::lc3b_word    mem_address,
	output lc3b_pkg::lc3b_word    mem_wdata
);

	lc3b_pkg::lc3b_word pc;
	lc3b_pkg::lc3b_word ir;
	lc3b_pkg::lc3b_word mar;
	lc3b_pkg::lc3b_word mdr;
	lc3b_pkg::lc3b_nzp  cc;
	lc3b_pkg::lc3b_nzp  cc_next;
	lc3b_pkg::lc3b_reg  src_a;
	lc3b_pkg::lc3b_word reg_a, reg_b;
	lc3b_pkg::lc3b_word alu_b, alu_out;
	lc3b_pkg::lc3b_word sext_imm5, sext_off6, sext_off9, zext_imm4;
	lc3b_pkg::lc3b_word pc_plus2, pc_offset, pc_next;
	lc3b_pkg::lc3b_word mdr_next, regfile_in;

	// Immediate fields with word scaled offsets
	assign sext_imm5 = {{11{ir[4]}}, ir[4:0]};
	assign sext_off6 = {{9{ir[5]}}, ir[5:0], 1'b0};
	assign sext_off9 = {{6{ir[8]}}, ir[8:0], 1'b0};
	assign zext_imm4 = {12'h000, ir[3:0]};

	// STR reads its source from IR[11:9]
	assign src_a = ctrl.storemux_sel ? ir[11:9] : ir[8:6];

	lc3b_regfile u_regfile (
		.clk   (clk),
		.load  (ctrl.load_regfile),
		.dest  (ir[11:9]),
		.src_a (src_a),
		.src_b (ir[2:0]),
		.in    (regfile_in),
		.reg_a (reg_a),
		.reg_b (reg_b)
	);

	always_comb begin
		case (ctrl.alumux_sel)
			2'b00: alu_b = reg_b;
			2'b01: alu_b = sext_imm5;
			2'b10: alu_b = sext_off6;
			default: alu_b = zext_imm4;
		endcase
	end

	lc3b_alu u_alu (
		.aluop (ctrl.aluop),
		.a     (reg_a),
		.b     (alu_b),
		.f     (alu_out)
	);

	assign pc_plus2 = pc + 16'd2;
	// PC was already advanced in fetch1
	assign pc_offset = pc + sext_off9;

	always_comb begin
		case (ctrl.pcmux_sel)
			2'b00: pc_next = pc_plus2;
			2'b01: pc_next = pc_offset;
			default: pc_next = alu_out;
		endcase
		case (ctrl.regfilemux_sel)
			2'b00: regfile_in = alu_out;
			2'b01: regfile_in = mdr;
			default: regfile_in = pc_offset;
		endcase
	end

	assign mdr_next = ctrl.mdrmux_sel ? mem_rdata : alu_out;

	// Flags follow the value going into the register file
	assign cc_next = {regfile_in[15], regfile_in == 16'h0000,
		!regfile_in[15] && regfile_in != 16'h0000};

	always_ff @(posedge clk) begin
		if (rst) begin
			pc <= RESET_PC;
		end else if (ctrl.load_pc) begin
			pc <= pc_next;
		end
	end

	always_ff @(posedge clk) begin
		if (ctrl.load_ir)
			ir <= mdr;
		if (ctrl.load_mar)
			mar <= ctrl.marmux_sel ? pc : alu_out;
		if (ctrl.load_mdr)
			mdr <= mdr_next;
		if (ctrl.load_cc)
			cc <= cc_next;
	end

	assign ir_info.opcode = ir[15:12];
	assign ir_info.imm_flag = ir[5];
	assign ir_info.shift_right = ir[4];
	assign ir_info.shift_arith = ir[5];
	assign ir_info.branch_enable = |(ir[11:9] & cc);

	assign mem_address = mar;
	assign mem_wdata = mdr;

endmodule

`default_nettype wire

/* src/lc3b_pkg.sv */
`default_nettype none

package lc3b_pkg;

	// Basic widths
	typedef logic [15:0] lc3b_word;
	typedef logic [3:0]  lc3b_opcode;
	typedef logic [2:0]  lc3b_reg;
	typedef logic [2:0]  lc3b_nzp;
	typedef logic [1:0]  lc3b_mem_wmask;
	typedef logic [2:0]  lc3b_aluop;
	typedef logic [1:0]  lc3b_mux_sel;

	// LC-3b opcode encodings for the supported subset
	localparam lc3b_opcode op_br  = 4'b0000;
	localparam lc3b_opcode op_add = 4'b0001;
	localparam lc3b_opcode op_and = 4'b0101;
	localparam lc3b_opcode op_ldr = 4'b0110;
	localparam lc3b_opcode op_str = 4'b0111;
	localparam lc3b_opcode op_not = 4'b1001;
	localparam lc3b_opcode op_jmp = 4'b1100;
	localparam lc3b_opcode op_shf = 4'b1101;
	localparam lc3b_opcode op_lea = 4'b1110;

	// ALU operations
	localparam lc3b_aluop alu_add  = 3'b000;
	localparam lc3b_aluop alu_and  = 3'b001;
	localparam lc3b_aluop alu_not  = 3'b010;
	localparam lc3b_aluop alu_pass = 3'b011;
	localparam lc3b_aluop alu_sll  = 3'b100;
	localparam lc3b_aluop alu_srl  = 3'b101;
	localparam lc3b_aluop alu_sra  = 3'b110;

	// Control bundle from the FSM to the datapath
	// pcmux selects 00 PC+2, 01 PC+offset9, 10 ALU (BaseR)
	// alumux selects 00 SR2, 01 imm5, 10 offset6, 11 imm4
	// regfilemux selects 00 ALU, 01 MDR, 10 PC+offset9
	typedef struct packed {
		logic        load_pc;
		logic        load_ir;
		logic        load_regfile;
		logic        load_mar;
		logic        load_mdr;
		logic        load_cc;
		lc3b_mux_sel pcmux_sel;
		logic        marmux_sel;
		lc3b_mux_sel alumux_sel;
		lc3b_mux_sel regfilemux_sel;
		logic        storemux_sel;
		logic        mdrmux_sel;
		lc3b_aluop   aluop;
	} lc3b_ctrl;

	// Decoded IR fields and branch test back to the FSM
	typedef struct packed {
		lc3b_opcode opcode;
		logic       imm_flag;
		logic       shift_right;
		logic       shift_arith;
		logic       branch_enable;
	} lc3b_ir_info;

endpackage

`default_nettype wire

/* src/lc3b_regfile.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_regfile (
	input  logic               clk,
	input  logic               load,
	input  lc3b_pkg::lc3b_reg  dest,
	input  lc3b_pkg::lc3b_reg  src_a,
	input  lc3b_pkg::lc3b_reg  src_b,
	input  lc3b_pkg::lc3b_word in,
	output lc3b_pkg::lc3b_word reg_a,
	output lc3b_pkg::lc3b_word reg_b
);

	lc3b_pkg::lc3b_word regs [8];

	// One write port on the clock edge
	always_ff @(posedge clk) begin
		if (load) begin
			regs[dest] <= in;
		end
	end

	// Reads are combinational
	assign reg_a = regs[src_a];
	assign reg_b = regs[src_b];

endmodule

`default_nettype wire

/* tb.f */
src/lc3b_pkg.sv
src/lc3b_alu.sv
src/lc3b_regfile.sv
src/lc3b_control.sv
src/lc3b_datapath.sv
src/lc3b_cpu.sv
testbench/lc3b_cpu_chk.sv
testbench/tb_lc3b_cpu.sv

/* testbench/lc3b_cpu_chk.sv */
`timescale 1ns/1ps
`default_nettype none

module lc3b_cpu_chk #(
	parameter lc3b_pkg::lc3b_word RESET_PC = 16'h0000
) (
	input logic                    clk,
	input logic                    rst,
	input lc3b_pkg::lc3b_word      mem_address,
	input lc3b_pkg::lc3b_word      mem_wdata,
	input logic                    mem_read,
	input logic                    mem_write,
	input lc3b_pkg::lc3b_mem_wmask mem_byte_enable,
	input logic                    mem_resp
);

	int fail_count = 0;
	logic first_pending;

	// Set until the first access after reset
	always_ff @(posedge clk) begin
		if (rst) begin
			first_pending <= 1'b1;
		end else if (mem_read || mem_write) begin
			first_pending <= 1'b0;
		end
	end

	idle_after_reset: assert property (@(posedge clk) rst |=> !mem_read && !mem_write)
		else begin
			$error("Memory strobe high right after reset");
			fail_count++;
		end

	first_read: assert property (@(posedge clk) disable iff (rst)
		first_pending && (mem_read || mem_write) |-> mem_read && mem_address == RESET_PC)
		else begin
			$error("First access after reset is not a read of the reset PC");
			fail_count++;
		end

	read_held: assert property (@(posedge clk) disable iff (rst)
		mem_read && !mem_resp |=> mem_read && $stable(mem_address))
		else begin
			$error("Read strobe or address changed before the response");
			fail_count++;
		end

	write_held: assert property (@(posedge clk) disable iff (rst)
		mem_write && !mem_resp |=> mem_write && $stable(mem_address) && $stable(mem_wdata))
		else begin
			$error("Write strobe, address or data changed before the response");
			fail_count++;
		end

	strobe_drops: assert property (@(posedge clk) disable iff (rst)
		(mem_read || mem_write) && mem_resp |=> !mem_read && !mem_write)
		else begin
			$error("Strobe still high in the cycle after the response");
			fail_count++;
		end

	one_strobe: assert property (@(posedge clk) disable iff (rst) !(mem_read && mem_write))
		else begin
			$error("Read and write strobes high together");
			fail_count++;
		end

	full_word: assert property (@(posedge clk) disable iff (rst) mem_byte_enable == 2'b11)
		else begin
			$error("Byte enable is not 2'b11");
			fail_count++;
		end

	store_known: assert property (@(posedge clk) disable iff (rst)
		mem_write |-> !$isunknown({mem_address, mem_wdata}))
		else begin
			$error("Store with unknown address or data");
			fail_count++;
		end

endmodule

`default_nettype wire

/* testbench/tb_lc3b_cpu.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_lc3b_cpu;

	localparam lc3b_pkg::lc3b_word RESET_PC = 16'h0000;

	logic clk = 1'b0;
	logic rst;
	lc3b_pkg::lc3b_word mem_address, mem_wdata, mem_rdata;
	logic mem_read, mem_write, mem_resp;
	lc3b_pkg::lc3b_mem_wmask mem_byte_enable;

	lc3b_pkg::lc3b_word mem [256];
	lc3b_pkg::lc3b_word exp_addr [$];
	lc3b_pkg::lc3b_word exp_data [$];
	int exp_group [$];
	int group_total [4] = '{default: 0};
	int group_seen [4] = '{default: 0};
	int group_err [4] = '{default: 0};
	string group_name [4] = '{"alu register and immediate", "shifts", "ldr and lea",
		"branch and jmp"};
	int next_idx, steps, exp_count, store_idx, checks, errors;
	int limit_cycles = 0;
	integer seed = 32'hf5852eda;

	always #4 clk = ~clk;

	lc3b_cpu #(.RESET_PC(RESET_PC)) DUT (
		.clk             (clk),
		.rst             (rst),
		.mem_address     (mem_address),
		.mem_wdata       (mem_wdata),
		.mem_read        (mem_read),
		.mem_write       (mem_write),
		.mem_byte_enable (mem_byte_enable),
		.mem_rdata       (mem_rdata),
		.mem_resp        (mem_resp)
	);

	bind lc3b_cpu lc3b_cpu_chk #(.RESET_PC(RESET_PC)) u_chk (
		.clk (clk), .rst (rst), .mem_address (mem_address), .mem_wdata (mem_wdata),
		.mem_read (mem_read), .mem_write (mem_write), .mem_byte_enable (mem_byte_enable),
		.mem_resp (mem_resp)
	);

	// {op, r11_9, r8_6, low6} and {op, r11_9, offset9}
	function automatic lc3b_pkg::lc3b_word fmt_rr(input lc3b_pkg::lc3b_opcode op,
		input logic [2:0] a, input logic [2:0] b, input logic [5:0] low6);
		return {op, a, b, low6};
	endfunction

	function automatic lc3b_pkg::lc3b_word fmt_off9(input lc3b_pkg::lc3b_opcode op,
		input logic [2:0] a, input logic [8:0] off9);
		return {op, a, off9};
	endfunction

	function automatic lc3b_pkg::lc3b_word sext(input lc3b_pkg::lc3b_word v, input int bits);
		lc3b_pkg::lc3b_word m;
		m = 16'hFFFF << bits;
		return v[bits-1] ? (v | m) : (v & ~m);
	endfunction

	task automatic emit(input lc3b_pkg::lc3b_word w);
		mem[next_idx] = w;
		next_idx++;
	endtask

	task automatic load_program;
		for (int i = 0; i < 256; i++) begin
			mem[i] = {8'h5A, i[7:0]};
		end
		next_idx = int'(RESET_PC[8:1]);
		emit(fmt_off9(lc3b_pkg::op_lea, 3'd6, 9'd127));
		emit(fmt_rr(lc3b_pkg::op_and, 3'd1, 3'd1, 6'h20));
		emit(fmt_rr(lc3b_pkg::op_add, 3'd1, 3'd1, 6'h25));
		emit(fmt_rr(lc3b_pkg::op_and, 3'd2, 3'd2, 6'h20));
		emit(fmt_rr(lc3b_pkg::op_add, 3'd2, 3'd2, 6'h3D));
		emit(fmt_rr(lc3b_pkg::op_add, 3'd3, 3'd1, 6'h02));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd0));
		emit(fmt_rr(lc3b_pkg::op_add, 3'd3, 3'd1, 6'h39));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd1));
		emit(fmt_rr(lc3b_pkg::op_and, 3'd3, 3'd1, 6'h02));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd2));
		emit(fmt_rr(lc3b_pkg::op_and, 3'd3, 3'd2, 6'h26));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd3));
		emit(fmt_rr(lc3b_pkg::op_not, 3'd3, 3'd2, 6'h3F));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd4));
		// Shift left, logical right, arithmetic right
		emit(fmt_rr(lc3b_pkg::op_shf, 3'd3, 3'd1, 6'h03));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd8));
		emit(fmt_rr(lc3b_pkg::op_shf, 3'd3, 3'd2, 6'h12));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd9));
		emit(fmt_rr(lc3b_pkg::op_shf, 3'd3, 3'd2, 6'h32));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd3, 3'd6, 6'd10));
		emit(fmt_rr(lc3b_pkg::op_ldr, 3'd4, 3'd6, 6'h3F));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd4, 3'd6, 6'd16));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd6, 3'd6, 6'd17));
		emit(fmt_off9(lc3b_pkg::op_lea, 3'd5, 9'h1FC));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd5, 3'd6, 6'd18));
		// Zero result, BRz taken over a wrong-path marker, BRn not taken
		emit(fmt_rr(lc3b_pkg::op_add, 3'd3, 3'd1, 6'h3B));
		emit(fmt_off9(lc3b_pkg::op_br, 3'b010, 9'd1));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd1, 3'd6, 6'd24));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd2, 3'd6, 6'd25));
		emit(fmt_off9(lc3b_pkg::op_br, 3'b100, 9'd1));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd1, 3'd6, 6'd26));
		emit(fmt_off9(lc3b_pkg::op_lea, 3'd7, 9'd3));
		emit(fmt_rr(lc3b_pkg::op_jmp, 3'd0, 3'd7, 6'd0));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd1, 3'd6, 6'd27));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd1, 3'd6, 6'd27));
		emit(fmt_rr(lc3b_pkg::op_str, 3'd7, 3'd6, 6'd28));
		// Halt as a branch to itself
		emit(fmt_off9(lc3b_pkg::op_br, 3'b111, 9'h1FF));
		mem[127] = 16'hA5C3;
	endtask

	// Instruction-level model that lists the expected stores in order
	task automatic run_reference;
		lc3b_pkg::lc3b_word img [256];
		lc3b_pkg::lc3b_word r [8];
		lc3b_pkg::lc3b_word pc, ir, addr, val, opnd;
		lc3b_pkg::lc3b_nzp cc;
		logic write_dr;
		img = mem;
		r = '{default: 16'h0000};
		pc = RESET_PC;
		cc = 3'b000;
		steps = 0;
		ir = img[pc[8:1]];
		while (ir != 16'h0FFF && steps < 1000) begin
			pc = pc + 16'd2;
			steps++;
			write_dr = 1'b1;
			opnd = ir[5] ? sext(ir, 5) : r[ir[2:0]];
			addr = r[ir[8:6]] + (sext(ir, 6) << 1);
			val = 16'h0000;
			case (ir[15:12])
				lc3b_pkg::op_add: val = r[ir[8:6]] + opnd;
				lc3b_pkg::op_and: val = r[ir[8:6]] & opnd;
				lc3b_pkg::op_not: val = ~r[ir[8:6]];
				lc3b_pkg::op_ldr: val = img[addr[8:1]];
				lc3b_pkg::op_lea: val = pc + (sext(ir, 9) << 1);
				lc3b_pkg::op_shf: begin
					if (!ir[4]) begin
						val = r[ir[8:6]] << ir[3:0];
					end else if (!ir[5]) begin
						val = r[ir[8:6]] >> ir[3:0];
					end else begin
						// Vacated upper bits take copies of the sign bit
						val = (r[ir[8:6]] >> ir[3:0]) |
							({16{r[ir[8:6]][15]}} & ~(16'hFFFF >> ir[3:0]));
					end
				end
				lc3b_pkg::op_str: begin
					img[addr[8:1]] = r[ir[11:9]];
					exp_addr.push_back(addr);
					exp_data.push_back(r[ir[11:9]]);
					exp_group.push_back(int'(ir[4:3]));
					write_dr = 1'b0;
				end
				lc3b_pkg::op_br: begin
					if (|(ir[11:9] & cc)) begin
						pc = pc + (sext(ir, 9) << 1);
					end
					write_dr = 1'b0;
				end
				lc3b_pkg::op_jmp: begin
					pc = r[ir[8:6]];
					write_dr = 1'b0;
				end
				default: write_dr = 1'b0;
			endcase
			if (write_dr) begin
				r[ir[11:9]] = val;
				cc = val[15] ? 3'b100 : ((val == 16'h0000) ? 3'b010 : 3'b001);
			end
			ir = img[pc[8:1]];
		end
		exp_count = exp_addr.size();
		foreach (exp_group[i]) begin
			group_total[exp_group[i]]++;
		end
	endtask

	task automatic check_store;
		int g;
		if (store_idx >= exp_count) begin
			$display("Unexpected store to address %h after the last expected one", mem_address);
			errors++;
		end else begin
			g = exp_group[store_idx];
			checks += 2;
			assert (mem_address == exp_addr[store_idx]) else begin
				$display("[ERROR] store %0d mem_address: expected %h, got %h",
					store_idx, exp_addr[store_idx], mem_address);
				errors++;
				group_err[g]++;
			end
			assert (mem_wdata == exp_data[store_idx]) else begin
				$display("[ERROR] store %0d mem_wdata: expected %h, got %h",
					store_idx, exp_data[store_idx], mem_wdata);
				errors++;
				group_err[g]++;
			end
			group_seen[g]++;
			if (group_seen[g] == group_total[g]) begin
				$display("Test %s: %0d stores, %s", group_name[g], group_total[g],
					group_err[g] == 0 ? "ok" : "failed");
			end
			store_idx++;
		end
	endtask

	// Memory with a random 1 to 4 cycle response delay
	initial begin : memory_model
		int wait_cycles;
		mem_resp = 1'b0;
		mem_rdata = 16'h0000;
		forever begin
			@(negedge clk);
			if (!rst && (mem_read || mem_write)) begin
				wait_cycles = ({$random(seed)} % 4) + 1;
				repeat (wait_cycles) @(negedge clk);
				if (mem_write) begin
					check_store();
					mem[mem_address[8:1]] = mem_wdata;
				end else begin
					mem_rdata = mem[mem_address[8:1]];
				end
				mem_resp = 1'b1;
				@(negedge clk);
				mem_resp = 1'b0;
			end
		end
	end

	initial begin : watchdog
		wait (limit_cycles > 0);
		repeat (limit_cycles) @(posedge clk);
		$display("Timeout after %0d cycles with %0d of %0d stores seen",
			limit_cycles, store_idx, exp_count);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin : main
		int chk_fails;
		rst = 1'b1;
		store_idx = 0;
		checks = 0;
		errors = 0;
		load_program();
		run_reference();
		limit_cycles = steps * 12 + 200;
		repeat (4) @(posedge clk);
		@(negedge clk);
		rst = 1'b0;
		while (store_idx < exp_count) begin
			@(negedge clk);
		end
		repeat (4) @(negedge clk);
		chk_fails = DUT.u_chk.fail_count;
		$display("Test memory protocol assertions: %0d failures", chk_fails);
		$display("Test latency and store order: %0d stores, %s", store_idx,
			errors == 0 ? "ok" : "failed");
		$display("Counts: %0d checks, %0d errors, %0d assertion failures",
			checks, errors, chk_fails);
		if (errors == 0 && chk_fails == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire
